/* hdl/pet_map_pkg.sv */
// Address map widths, region bounds and decode result types shared by the decode modules.
package pet_map_pkg;

    localparam int CPU_ADDR_WIDTH = 16;     // The 6502 drives a 16-bit address bus.
    localparam int DATA_WIDTH     = 8;      // The data bus is one byte wide.

    typedef logic [CPU_ADDR_WIDTH-1:0] cpu_addr_t;
    typedef logic [DATA_WIDTH-1:0]     cpu_data_t;

    // Bounds of the base map. The upper end of ROM is the top of the address space.
    localparam cpu_addr_t RAM_END    = 16'h7FFF;
    localparam cpu_addr_t VRAM_START = 16'h8000;
    localparam cpu_addr_t VRAM_END   = 16'h8EFF;
    localparam cpu_addr_t SID_START  = 16'h8F00;   // The SID sits in the unused tail of the screen.
    localparam cpu_addr_t SID_END    = 16'h8FFF;
    localparam cpu_addr_t ROM_START  = 16'h9000;

    // The I/O page and the device windows inside it.
    localparam cpu_addr_t IO_START   = 16'hE800;
    localparam cpu_addr_t IO_END     = 16'hEFFF;
    localparam cpu_addr_t PIA1_START = 16'hE810;
    localparam cpu_addr_t PIA1_END   = 16'hE81F;
    localparam cpu_addr_t PIA2_START = 16'hE820;
    localparam cpu_addr_t PIA2_END   = 16'hE83F;
    localparam cpu_addr_t VIA_START  = 16'hE840;
    localparam cpu_addr_t VIA_END    = 16'hE87F;
    localparam cpu_addr_t CRTC_START = 16'hE880;
    localparam cpu_addr_t CRTC_END   = 16'hE8FF;

    // The expansion replaces $8000-$FFFF in two 16K halves.
    localparam cpu_addr_t EXP_LO_START = 16'h8000;
    localparam cpu_addr_t EXP_HI_START = 16'hC000;

    // One select per I/O device. At most one bit is set.
    typedef struct packed {
        logic pia1;
        logic pia2;
        logic via;
        logic crtc;
    } io_sel_t;

    // Result of the expansion mapping for one address.
    typedef struct packed {
        logic active;       // The expansion owns this address.
        logic a16;          // Physical address bit 16.
        logic a15;          // Physical address bit 15, the block within the pair.
        logic readonly;     // Writes to this block are blocked.
    } exp_map_t;

endpackage

/* hdl/mem_ctl_pkg.sv */
// Layout, reset value and bus address of the memory control register, used by its writer and readers.
package mem_ctl_pkg;

    // The CPU reaches the register at $FFF0, which is the default the top level passes down.
    localparam pet_map_pkg::cpu_addr_t MEM_CTL_ADDR = 16'hFFF0;

    // Bit positions within the control byte.
    localparam int ENABLED     = 7;     // Turns the 64K expansion on.
    localparam int IO_PEEK     = 6;     // Keeps the I/O page visible while the upper half is mapped.
    localparam int SCREEN_PEEK = 5;     // Keeps the screen visible while the lower half is mapped.
    // Bit 4 has no function and is ignored on writes.
    localparam int SELECT_32   = 3;     // Picks block 3 over block 2 for $C000-$FFFF.
    localparam int SELECT_10   = 2;     // Picks block 1 over block 0 for $8000-$BFFF.
    localparam int PROTECT_32  = 1;     // Write protects $C000-$FFFF.
    localparam int PROTECT_10  = 0;     // Write protects $8000-$BFFF.

    // After reset the expansion is off and the machine shows its stock map.
    localparam pet_map_pkg::cpu_data_t MEM_CTL_RESET = 8'h00;

endpackage

/* hdl/mem_ctl_if.sv */
// Carries the memory control fields from the register block to the address decoder.
`timescale 1ns/1ps

interface mem_ctl_if;

    logic enabled;          // Expansion is switched on.
    logic io_peek;          // I/O page stays visible in the upper half.
    logic screen_peek;      // Screen stays visible in the lower half.
    logic select_32;        // Block 3 when set, block 2 when clear.
    logic select_10;        // Block 1 when set, block 0 when clear.
    logic protect_32;       // Upper half is read only.
    logic protect_10;       // Lower half is read only.

    // The register block owns every field.
    modport reg_side (
        output enabled, io_peek, screen_peek, select_32, select_10, protect_32, protect_10
    );

    // The mapping logic only looks at them.
    modport map_side (
        input enabled, io_peek, screen_peek, select_32, select_10, protect_32, protect_10
    );

endinterface

/* hdl/mem_ctl_reg.sv */
// Memory control register that latches a CPU write at its bus address and exports the fields.
`timescale 1ns/1ps

module mem_ctl_reg import pet_map_pkg::*, mem_ctl_pkg::*; #(
    parameter cpu_addr_t REG_ADDR = MEM_CTL_ADDR    // Bus address the register answers to.
) (
    input  logic               sys_clock,
    input  logic               reset_i,
    input  cpu_addr_t          cpu_addr_i,
    input  cpu_data_t          cpu_data_i,
    input  logic               cpu_wr_strobe_i,    // High for one clock per CPU write.
    mem_ctl_if.reg_side        ctl_o
);

    logic wr_hit;   // This clock carries a write to the register.

    assign wr_hit = cpu_wr_strobe_i && (cpu_addr_i == REG_ADDR);

    // Each field is its own flop. Bit 4 of the data byte is not stored.
    always_ff @(posedge sys_clock) begin
        if (reset_i) begin
            ctl_o.enabled     <= MEM_CTL_RESET[ENABLED];
            ctl_o.io_peek     <= MEM_CTL_RESET[IO_PEEK];
            ctl_o.screen_peek <= MEM_CTL_RESET[SCREEN_PEEK];
            ctl_o.select_32   <= MEM_CTL_RESET[SELECT_32];
            ctl_o.select_10   <= MEM_CTL_RESET[SELECT_10];
            ctl_o.protect_32  <= MEM_CTL_RESET[PROTECT_32];
            ctl_o.protect_10  <= MEM_CTL_RESET[PROTECT_10];
        end else if (wr_hit) begin
            // The new value takes effect for the address decoded on the next clock.
            ctl_o.enabled     <= cpu_data_i[ENABLED];
            ctl_o.io_peek     <= cpu_data_i[IO_PEEK];
            ctl_o.screen_peek <= cpu_data_i[SCREEN_PEEK];
            ctl_o.select_32   <= cpu_data_i[SELECT_32];
            ctl_o.select_10   <= cpu_data_i[SELECT_10];
            ctl_o.protect_32  <= cpu_data_i[PROTECT_32];
            ctl_o.protect_10  <= cpu_data_i[PROTECT_10];
        end
    end

endmodule

/* hdl/io_select.sv */
// Combinational chip selects for the PIAs, the VIA and the CRTC inside the $E800 page.
`timescale 1ns/1ps

module io_select import pet_map_pkg::*; (
    input  cpu_addr_t cpu_addr_i,
    output io_sel_t   sel_o
);

    logic in_pia1;
    logic in_pia2;
    logic in_via;
    logic in_crtc;

    // The four windows are disjoint, so at most one of these is set.
    assign in_pia1 = (cpu_addr_i >= PIA1_START) && (cpu_addr_i <= PIA1_END);   // 16 bytes.
    assign in_pia2 = (cpu_addr_i >= PIA2_START) && (cpu_addr_i <= PIA2_END);   // 32 bytes.
    assign in_via  = (cpu_addr_i >= VIA_START)  && (cpu_addr_i <= VIA_END);    // 64 bytes.
    assign in_crtc = (cpu_addr_i >= CRTC_START) && (cpu_addr_i <= CRTC_END);   // 128 bytes.

    // $E800-$E80F and $E900-$EFFF fall through with no device selected.
    // The decoder treats those holes as ROM.
    always_comb begin
        sel_o      = '0;
        sel_o.pia1 = in_pia1;
        sel_o.pia2 = in_pia2;
        sel_o.via  = in_via;
        sel_o.crtc = in_crtc;
    end

endmodule

/* hdl/expansion_map.sv */
// Combinational mapping of $8000-$FFFF into the 64K expansion blocks, with protect and peek-through.
`timescale 1ns/1ps

module expansion_map import pet_map_pkg::*; (
    input  cpu_addr_t          cpu_addr_i,
    mem_ctl_if.map_side        ctl_i,
    output exp_map_t           map_o
);

    logic in_expansion;     // Address is in the part of the map the expansion can replace.
    logic upper_half;       // Address is in $C000-$FFFF.
    logic in_screen;        // Address is in the screen window $8000-$8FFF.
    logic in_io;            // Address is in the I/O page $E800-$EFFF.
    logic screen_hole;      // Screen peek-through applies here.
    logic io_hole;          // I/O peek-through applies here.
    logic block_bit;        // Block choice of the half that holds the address.
    logic protect_bit;      // Write protect of that half.

    assign in_expansion = (cpu_addr_i >= EXP_LO_START);
    assign upper_half   = (cpu_addr_i >= EXP_HI_START);

    // The screen window covers video RAM and the SID behind it.
    assign in_screen = (cpu_addr_i >= VRAM_START) && (cpu_addr_i <= SID_END);
    assign in_io     = (cpu_addr_i >= IO_START) && (cpu_addr_i <= IO_END);

    assign screen_hole = ctl_i.screen_peek && in_screen;
    assign io_hole     = ctl_i.io_peek && in_io;

    // Each half carries its own block select and protect bit.
    always_comb begin
        if (upper_half) begin
            block_bit   = ctl_i.select_32;      // Block 2 or 3.
            protect_bit = ctl_i.protect_32;
        end else begin
            block_bit   = ctl_i.select_10;      // Block 0 or 1.
            protect_bit = ctl_i.protect_10;
        end
    end

    always_comb begin
        map_o = '0;

        // A peek-through hole hands the address back to the base map.
        map_o.active = ctl_i.enabled && in_expansion && !screen_hole && !io_hole;

        if (map_o.active) begin
            map_o.a16      = 1'b1;          // Expansion blocks sit above the first 64K.
            map_o.a15      = block_bit;
            map_o.readonly = protect_bit;
        end
    end

endmodule

/* hdl/address_decoder.sv */
// Registered address decoder that merges the base map with the expansion mapping.
`timescale 1ns/1ps

module address_decoder import pet_map_pkg::*; (
    input  logic               sys_clock,
    input  logic               reset_i,
    input  cpu_addr_t          cpu_addr_i,
    mem_ctl_if.map_side        ctl_i,
    output logic               ram_en_o,
    output logic               pia1_en_o,
    output logic               pia2_en_o,
    output logic               via_en_o,
    output logic               crtc_en_o,
    output logic               sid_en_o,
    output logic               io_en_o,
    output logic               is_vram_o,
    output logic               is_readonly_o,
    output logic               decoded_a15_o,
    output logic               decoded_a16_o
);

    // Everything the decoder drives, kept together for the single output register.
    typedef struct packed {
        logic ram_en;
        logic pia1_en;
        logic pia2_en;
        logic via_en;
        logic crtc_en;
        logic sid_en;
        logic io_en;
        logic is_vram;
        logic is_readonly;
        logic a16;
        logic a15;
    } dec_out_t;

    io_sel_t  io_sel;       // Device selects for the current address.
    exp_map_t exp_map;      // Expansion result for the current address.
    dec_out_t dec_nxt;
    dec_out_t dec_q;

    io_select i_io_select (
        .cpu_addr_i (cpu_addr_i),
        .sel_o      (io_sel)
    );

    expansion_map i_expansion_map (
        .cpu_addr_i (cpu_addr_i),
        .ctl_i      (ctl_i),
        .map_o      (exp_map)
    );

    always_comb begin
        dec_nxt = '0;

        if (cpu_addr_i <= RAM_END) begin
            dec_nxt.ram_en = 1'b1;          // Main RAM in the first 32K, a16/a15 stay 00.
        end else begin
            dec_nxt.a15 = 1'b1;             // The rest of the stock map lives at $8000 physical.

            if ((cpu_addr_i >= VRAM_START) && (cpu_addr_i <= VRAM_END)) begin
                dec_nxt.ram_en  = 1'b1;
                dec_nxt.is_vram = 1'b1;
            end else if ((cpu_addr_i >= SID_START) && (cpu_addr_i <= SID_END)) begin
                dec_nxt.sid_en = 1'b1;      // The SID answers instead of RAM.
            end else if (cpu_addr_i >= ROM_START) begin
                if (|io_sel) begin
                    // A selected device takes the bus away from ROM.
                    dec_nxt.pia1_en = io_sel.pia1;
                    dec_nxt.pia2_en = io_sel.pia2;
                    dec_nxt.via_en  = io_sel.via;
                    dec_nxt.crtc_en = io_sel.crtc;
                    dec_nxt.io_en   = io_sel.pia1 | io_sel.pia2 | io_sel.via;  // Not the CRTC.
                end else begin
                    dec_nxt.ram_en      = 1'b1;     // ROM images live in RAM that is read only.
                    dec_nxt.is_readonly = 1'b1;
                end
            end
        end

        // An active expansion overrides the whole base result with a plain RAM access.
        if (exp_map.active) begin
            dec_nxt             = '0;
            dec_nxt.ram_en      = 1'b1;
            dec_nxt.a16         = exp_map.a16;
            dec_nxt.a15         = exp_map.a15;
            dec_nxt.is_readonly = exp_map.readonly;
        end
    end

    always_ff @(posedge sys_clock) begin
        if (reset_i) begin
            dec_q <= '0;
        end else begin
            dec_q <= dec_nxt;   // One address per clock, valid until the next edge.
        end
    end

    assign ram_en_o      = dec_q.ram_en;
    assign pia1_en_o     = dec_q.pia1_en;
    assign pia2_en_o     = dec_q.pia2_en;
    assign via_en_o      = dec_q.via_en;
    assign crtc_en_o     = dec_q.crtc_en;
    assign sid_en_o      = dec_q.sid_en;
    assign io_en_o       = dec_q.io_en;
    assign is_vram_o     = dec_q.is_vram;
    assign is_readonly_o = dec_q.is_readonly;
    assign decoded_a15_o = dec_q.a15;
    assign decoded_a16_o = dec_q.a16;

endmodule

/* hdl/pet_decode_top.sv */
// Top level of the address decode, placing the memory control register beside the decoder.
`timescale 1ns/1ps

module pet_decode_top import pet_map_pkg::*, mem_ctl_pkg::*; #(
    parameter cpu_addr_t MEM_CTL_REG_ADDR = MEM_CTL_ADDR   // Where the CPU finds the register.
) (
    input  logic      sys_clock,
    input  logic      reset_i,
    input  cpu_addr_t cpu_addr_i,
    input  cpu_data_t cpu_data_i,
    input  logic      cpu_wr_strobe_i,
    output logic      ram_en_o,
    output logic      pia1_en_o,
    output logic      pia2_en_o,
    output logic      via_en_o,
    output logic      crtc_en_o,
    output logic      sid_en_o,
    output logic      io_en_o,
    output logic      is_vram_o,
    output logic      is_readonly_o,
    output logic      decoded_a15_o,
    output logic      decoded_a16_o
);

    // Register fields on their way to the decoder.
    mem_ctl_if i_mem_ctl_if ();

    mem_ctl_reg #(
        .REG_ADDR (MEM_CTL_REG_ADDR)
    ) i_mem_ctl_reg (
        .sys_clock       (sys_clock),
        .reset_i         (reset_i),
        .cpu_addr_i      (cpu_addr_i),
        .cpu_data_i      (cpu_data_i),
        .cpu_wr_strobe_i (cpu_wr_strobe_i),
        .ctl_o           (i_mem_ctl_if.reg_side)
    );

    // The decoder sees a register write one clock after the write is captured.
    address_decoder i_address_decoder (
        .sys_clock     (sys_clock),
        .reset_i       (reset_i),
        .cpu_addr_i    (cpu_addr_i),
        .ctl_i         (i_mem_ctl_if.map_side),
        .ram_en_o      (ram_en_o),
        .pia1_en_o     (pia1_en_o),
        .pia2_en_o     (pia2_en_o),
        .via_en_o      (via_en_o),
        .crtc_en_o     (crtc_en_o),
        .sid_en_o      (sid_en_o),
        .io_en_o       (io_en_o),
        .is_vram_o     (is_vram_o),
        .is_readonly_o (is_readonly_o),
        .decoded_a15_o (decoded_a15_o),
        .decoded_a16_o (decoded_a16_o)
    );

endmodule

/* sim/pet_decode_tb.sv */
// Self-checking testbench that walks a table of address ranges through the decoder top level.
`timescale 1ns/1ps

module pet_decode_tb import pet_map_pkg::*, mem_ctl_pkg::*; ();

    localparam int RESET_CYCLES     = 5;
    localparam int RANDOM_PER_ENTRY = 4;     // Drawn addresses per entry, on top of both ends.
    // The table takes about three hundred cycles with reset and writes, so this leaves room.
    localparam int MAX_CYCLES       = 2000;

    // Expected outputs, column order {ram pia1 pia2 via crtc, sid io vram ro, a16 a15}.
    localparam logic [10:0] EXP_NONE        = 11'b0_0000_0000_00;
    localparam logic [10:0] EXP_RAM         = 11'b1_0000_0000_00;
    localparam logic [10:0] EXP_VRAM        = 11'b1_0000_0010_01;
    localparam logic [10:0] EXP_SID         = 11'b0_0000_1000_01;
    localparam logic [10:0] EXP_ROM         = 11'b1_0000_0001_01;
    localparam logic [10:0] EXP_PIA1        = 11'b0_1000_0100_01;
    localparam logic [10:0] EXP_PIA2        = 11'b0_0100_0100_01;
    localparam logic [10:0] EXP_VIA         = 11'b0_0010_0100_01;
    localparam logic [10:0] EXP_CRTC        = 11'b0_0001_0000_01;   // The CRTC has no io_en.
    localparam logic [10:0] EXP_BLK_EVEN    = 11'b1_0000_0000_10;   // Block 0 or 2, writable.
    localparam logic [10:0] EXP_BLK_EVEN_RO = 11'b1_0000_0001_10;
    localparam logic [10:0] EXP_BLK_ODD     = 11'b1_0000_0000_11;   // Block 1 or 3, writable.
    localparam logic [10:0] EXP_BLK_ODD_RO  = 11'b1_0000_0001_11;

    // One table row: an optional register write, then a range that decodes to one result.
    typedef struct packed {
        logic        do_write;
        cpu_addr_t   wr_addr;
        cpu_data_t   wr_data;
        cpu_addr_t   lo;
        cpu_addr_t   hi;
        logic [10:0] exp_bits;
    } entry_t;

    logic      sys_clock;
    logic      reset_i;
    cpu_addr_t cpu_addr_i;
    cpu_data_t cpu_data_i;
    logic      cpu_wr_strobe_i;
    logic      ram_en_o;
    logic      pia1_en_o;
    logic      pia2_en_o;
    logic      via_en_o;
    logic      crtc_en_o;
    logic      sid_en_o;
    logic      io_en_o;
    logic      is_vram_o;
    logic      is_readonly_o;
    logic      decoded_a15_o;
    logic      decoded_a16_o;

    entry_t    table_q[$];
    cpu_addr_t cur_addr;            // Address whose result is being checked.
    int        error_count = 0;
    int        check_count = 0;
    int        cycle_count = 0;
    integer    seed = 18;

    pet_decode_top #(
        .MEM_CTL_REG_ADDR (MEM_CTL_ADDR)
    ) i_dut (
        .sys_clock       (sys_clock),
        .reset_i         (reset_i),
        .cpu_addr_i      (cpu_addr_i),
        .cpu_data_i      (cpu_data_i),
        .cpu_wr_strobe_i (cpu_wr_strobe_i),
        .ram_en_o        (ram_en_o),
        .pia1_en_o       (pia1_en_o),
        .pia2_en_o       (pia2_en_o),
        .via_en_o        (via_en_o),
        .crtc_en_o       (crtc_en_o),
        .sid_en_o        (sid_en_o),
        .io_en_o         (io_en_o),
        .is_vram_o       (is_vram_o),
        .is_readonly_o   (is_readonly_o),
        .decoded_a15_o   (decoded_a15_o),
        .decoded_a16_o   (decoded_a16_o)
    );

    initial begin
        sys_clock = 1'b0;
        forever #2 sys_clock = ~sys_clock;      // 4 ns period.
    end

    always @(posedge sys_clock) cycle_count <= cycle_count + 1;

    // Watchdog on the cycle counter.
    initial begin
        wait (cycle_count >= MAX_CYCLES);
        $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
        $display("Errors: %0d of %0d checks", error_count, check_count);
        $display("Simulation failed");
        $finish;
    end

    // Control byte built from the register's bit positions.
    function automatic cpu_data_t ctl_byte(input logic en, input logic io_pk, input logic scr_pk,
                                           input logic sel32, input logic sel10,
                                           input logic prot32, input logic prot10);
        cpu_data_t b;
        b              = '0;
        b[ENABLED]     = en;
        b[IO_PEEK]     = io_pk;
        b[SCREEN_PEEK] = scr_pk;
        b[SELECT_32]   = sel32;
        b[SELECT_10]   = sel10;
        b[PROTECT_32]  = prot32;
        b[PROTECT_10]  = prot10;
        return b;
    endfunction

    task automatic add_write(input cpu_addr_t wr_addr, input cpu_data_t wr_data,
                             input cpu_addr_t lo, input cpu_addr_t hi, input logic [10:0] exp);
        entry_t e;
        e.do_write = 1'b1;
        e.wr_addr  = wr_addr;
        e.wr_data  = wr_data;
        e.lo       = lo;
        e.hi       = hi;
        e.exp_bits = exp;
        table_q.push_back(e);
    endtask

    task automatic add_range(input cpu_addr_t lo, input cpu_addr_t hi, input logic [10:0] exp);
        entry_t e;
        e          = '0;       // No write ahead of this range.
        e.lo       = lo;
        e.hi       = hi;
        e.exp_bits = exp;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        cpu_data_t ctl_plain;
        cpu_data_t ctl_both_odd_ro;
        cpu_data_t ctl_lo_odd_ro;
        cpu_data_t ctl_hi_odd_ro;
        cpu_data_t ctl_lo_odd_hi_ro;
        cpu_data_t ctl_lo_ro_hi_odd;
        cpu_data_t ctl_screen;
        cpu_data_t ctl_io;
        ctl_plain        = ctl_byte(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        ctl_both_odd_ro  = ctl_byte(1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1);
        ctl_lo_odd_ro    = ctl_byte(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
        ctl_hi_odd_ro    = ctl_byte(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
        ctl_lo_odd_hi_ro = ctl_byte(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
        ctl_lo_ro_hi_odd = ctl_byte(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        ctl_screen       = ctl_byte(1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
        ctl_io           = ctl_byte(1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        // Stock map straight out of reset.
        add_range(16'h0000, 16'h7FFF, EXP_RAM);
        add_range(16'h8000, 16'h8EFF, EXP_VRAM);
        add_range(16'h8F00, 16'h8FFF, EXP_SID);
        add_range(16'h9000, 16'hE7FF, EXP_ROM);
        add_range(16'hE800, 16'hE80F, EXP_ROM);     // Hole below PIA1.
        add_range(16'hE810, 16'hE81F, EXP_PIA1);
        add_range(16'hE820, 16'hE83F, EXP_PIA2);
        add_range(16'hE840, 16'hE87F, EXP_VIA);
        add_range(16'hE880, 16'hE8FF, EXP_CRTC);
        add_range(16'hE900, 16'hEFFF, EXP_ROM);     // Rest of the I/O page.
        add_range(16'hF000, 16'hFFFF, EXP_ROM);
        // Each half walks through all four block and protect pairs.
        add_write(MEM_CTL_ADDR, ctl_plain, 16'h0000, 16'h7FFF, EXP_RAM);
        add_range(16'h8000, 16'hBFFF, EXP_BLK_EVEN);
        add_range(16'hC000, 16'hFFFF, EXP_BLK_EVEN);
        add_write(MEM_CTL_ADDR, ctl_both_odd_ro, 16'h8000, 16'hBFFF, EXP_BLK_ODD_RO);
        add_range(16'hC000, 16'hFFFF, EXP_BLK_ODD_RO);
        add_write(MEM_CTL_ADDR, ctl_lo_odd_ro, 16'h8000, 16'hBFFF, EXP_BLK_ODD_RO);
        add_range(16'hC000, 16'hFFFF, EXP_BLK_EVEN);
        add_write(MEM_CTL_ADDR, ctl_hi_odd_ro, 16'h8000, 16'hBFFF, EXP_BLK_EVEN);
        add_range(16'hC000, 16'hFFFF, EXP_BLK_ODD_RO);
        add_write(MEM_CTL_ADDR, ctl_lo_odd_hi_ro, 16'h8000, 16'hBFFF, EXP_BLK_ODD);
        add_range(16'hC000, 16'hFFFF, EXP_BLK_EVEN_RO);
        add_write(MEM_CTL_ADDR, ctl_lo_ro_hi_odd, 16'h8000, 16'hBFFF, EXP_BLK_EVEN_RO);
        add_range(16'hC000, 16'hFFFF, EXP_BLK_ODD);
        // Screen peek gives back $8000-$8FFF only.
        add_write(MEM_CTL_ADDR, ctl_screen, 16'h8000, 16'h8EFF, EXP_VRAM);
        add_range(16'h8F00, 16'h8FFF, EXP_SID);
        add_range(16'h9000, 16'hBFFF, EXP_BLK_ODD);
        add_range(16'hC000, 16'hFFFF, EXP_BLK_EVEN);
        // I/O peek gives back $E800-$EFFF only
        add_write(MEM_CTL_ADDR, ctl_io, 16'h8000, 16'h8FFF, EXP_BLK_EVEN_RO);
        add_range(16'h9000, 16'hBFFF, EXP_BLK_EVEN_RO);
        add_range(16'hC000, 16'hE7FF, EXP_BLK_ODD);
        add_range(16'hE800, 16'hE80F, EXP_ROM);
        add_range(16'hE810, 16'hE81F, EXP_PIA1);
        add_range(16'hE820, 16'hE83F, EXP_PIA2);
        add_range(16'hE840, 16'hE87F, EXP_VIA);
        add_range(16'hE880, 16'hE8FF, EXP_CRTC);
        add_range(16'hE900, 16'hEFFF, EXP_ROM);
        add_range(16'hF000, 16'hFFFF, EXP_BLK_ODD);
        // Strobes next to the register must not touch it.
        add_write(16'hFFF1, 8'h00, 16'hC000, 16'hE7FF, EXP_BLK_ODD);
        add_write(16'h7FF0, 8'h00, 16'h8000, 16'hBFFF, EXP_BLK_EVEN_RO);
        // Switching the expansion off brings the stock map back.
        add_write(MEM_CTL_ADDR, 8'h00, 16'h8000, 16'h8EFF, EXP_VRAM);
        add_range(16'hF000, 16'hFFFF, EXP_ROM);
    endtask

    task automatic check_value(input string name, input logic actual, input logic expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch %s at address 0x%04h: got 0x%0h, expected 0x%0h",
                     name, cur_addr, actual, expected);
        end
    endtask

    task automatic check_outputs(input logic [10:0] exp);
        check_value("ram_en_o",      ram_en_o,      exp[10]);
        check_value("pia1_en_o",     pia1_en_o,     exp[9]);
        check_value("pia2_en_o",     pia2_en_o,     exp[8]);
        check_value("via_en_o",      via_en_o,      exp[7]);
        check_value("crtc_en_o",     crtc_en_o,     exp[6]);
        check_value("sid_en_o",      sid_en_o,      exp[5]);
        check_value("io_en_o",       io_en_o,       exp[4]);
        check_value("is_vram_o",     is_vram_o,     exp[3]);
        check_value("is_readonly_o", is_readonly_o, exp[2]);
        check_value("decoded_a16_o", decoded_a16_o, exp[1]);
        check_value("decoded_a15_o", decoded_a15_o, exp[0]);
    endtask

    // Called 1 ns after an edge; the result shows 1 ns after the next one.
    task automatic apply_and_check(input cpu_addr_t addr, input logic [10:0] exp);
        cpu_addr_i = addr;
        @(posedge sys_clock);
        #1;
        cur_addr = addr;
        check_outputs(exp);
    endtask

    // One strobed write. The decode of the write cycle itself is not checked.
    task automatic write_ctl(input cpu_addr_t addr, input cpu_data_t data);
        cpu_addr_i      = addr;
        cpu_data_i      = data;
        cpu_wr_strobe_i = 1'b1;
        @(posedge sys_clock);
        #1;
        cpu_wr_strobe_i = 1'b0;
        cpu_data_i      = '0;
    endtask

    initial begin
        entry_t    e;
        integer    rnd;
        int        span;
        int        off;
        int        i;
        int        k;
        reset_i         = 1'b1;
        cpu_addr_i      = 16'h8000;     // Would select VRAM if reset let it through.
        cpu_data_i      = '0;
        cpu_wr_strobe_i = 1'b0;
        cur_addr        = 16'h8000;
        build_table();
        for (i = 0; i < RESET_CYCLES; i++) begin
            @(posedge sys_clock);
            #1;
            check_outputs(EXP_NONE);    // Outputs held low while in reset.
        end
        reset_i = 1'b0;
        for (i = 0; i < table_q.size(); i++) begin
            e = table_q[i];
            if (e.do_write) begin
                write_ctl(e.wr_addr, e.wr_data);
            end
            apply_and_check(e.lo, e.exp_bits);
            apply_and_check(e.hi, e.exp_bits);
            span = int'(e.hi) - int'(e.lo) + 1;
            for (k = 0; k < RANDOM_PER_ENTRY; k++) begin
                rnd = $random(seed);
                off = (rnd & 32'h7FFF_FFFF) % span;     // Keep the offset inside the range.
                apply_and_check(e.lo + cpu_addr_t'(off), e.exp_bits);
            end
        end
        $display("Errors: %0d of %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* pet_decode.f */
hdl/pet_map_pkg.sv
hdl/mem_ctl_pkg.sv
hdl/mem_ctl_if.sv
hdl/mem_ctl_reg.sv
hdl/io_select.sv
hdl/expansion_map.sv
hdl/address_decoder.sv
hdl/pet_decode_top.sv
sim/pet_decode_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the decoder testbench with Verilator, runs it and judges the log.

ROOT_DIR=$(cd "$(dirname "$0")" && pwd)
cd "$ROOT_DIR" || exit 1

LOG_FILE=sim.log
SIM_BIN=pet_decode_sim

verilator --binary --timing --top-module pet_decode_tb -f pet_decode.f -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "Simulation binary exited with status $status"
    exit 1
fi

if grep -q "Simulation passed" "$LOG_FILE"; then
    echo "Run result: PASS"
    exit 0
else
    echo "Run result: FAIL"
    exit 1
fi
